//--- logic/dec_pkg.sv
////////////////////////////////////////////////////////////
// dec_pkg
//   fetch, debug and decode packet structs
//   debug command type, major opcode and op class enums
//   buffer depth, reset pc and debug encoding constants
////////////////////////////////////////////////////////////

package dec_pkg;

   localparam int IB_DEPTH = 4;                       // instruction buffer entries
   localparam int IB_PTR_W = $clog2(IB_DEPTH);        // read/write pointer width
   localparam int IB_CNT_W = $clog2(IB_DEPTH + 1);    // occupancy 0..IB_DEPTH

   localparam logic [11:0] DEBUG_FENCE_CSR = 12'h7c4; // debug-only fence csr
   localparam logic [31:1] RESET_PC        = 31'h0;   // pc[31:1] after reset

   // funct3 values used by the debug instructions and the decoder
   localparam logic [2:0] F3_OR    = 3'b110;
   localparam logic [2:0] F3_CSRRW = 3'b001;
   localparam logic [2:0] F3_CSRRS = 3'b010;
   localparam logic [2:0] F3_PRIV  = 3'b000;          // ecall/ebreak/mret group

   typedef enum logic [1:0] {
      DBG_GPR  = 2'd0,
      DBG_CSR  = 2'd1,
      DBG_MEM  = 2'd2,                                // not handled here
      DBG_RSVD = 2'd3
   } dbg_type_e;

   // major opcode, instr[6:2] of a 32-bit word
   typedef enum logic [4:0] {
      MAJ_LOAD   = 5'b00000,
      MAJ_OP_IMM = 5'b00100,
      MAJ_STORE  = 5'b01000,
      MAJ_OP     = 5'b01100,
      MAJ_BRANCH = 5'b11000,
      MAJ_JALR   = 5'b11001,
      MAJ_JAL    = 5'b11011,
      MAJ_SYSTEM = 5'b11100
   } major_op_e;

   localparam logic [6:0] OPC_REG = {MAJ_OP, 2'b11};     // full 7-bit reg-reg opcode
   localparam logic [6:0] OPC_SYS = {MAJ_SYSTEM, 2'b11}; // full 7-bit system opcode

   typedef enum logic [3:0] {
      OP_ALU, OP_ALU_IMM, OP_LOAD, OP_STORE, OP_BRANCH, OP_JAL,
      OP_JALR, OP_CSR, OP_SYSTEM, OP_COMPRESSED, OP_ILLEGAL
   } op_class_e;

   typedef struct packed {
      logic [31:0] instr;
      logic [31:1] pc;
      logic        pc4;                               // 4B inst, else 2B
      logic        icaf;                              // access fault
      logic [1:0]  icaf_type;
      logic        dbecc;                             // double-bit ecc error
   } fetch_pkt_t;

   typedef struct packed {
      logic        write;
      dbg_type_e   cmd_type;
      logic [31:0] addr;
   } dbg_cmd_t;

   typedef struct packed {
      logic       valid;
      fetch_pkt_t inst;
      logic       is_debug;                           // built from a debug command
      logic       wdata_rs1;                          // debug write data on rs1
      logic       debug_fence;
   } dec_pkt_t;

   typedef struct packed {
      fetch_pkt_t inst;
      logic       is_debug;
      logic       wdata_rs1;
      logic       debug_fence;
      op_class_e  op_class;
      logic [4:0] rd;
      logic [4:0] rs1;
   } dec_out_t;

endpackage

//--- logic/fetch_pack.sv
////////////////////////////////////////////////////////////
// fetch_pack
//   fetch word register with length detect
//   sequential pc tracking and redirect load
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_pack (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 fetch_valid,
   input  logic [31:0]          fetch_instr,
   input  logic                 fetch_icaf,
   input  logic [1:0]           fetch_icaf_type,
   input  logic                 fetch_dbecc,
   input  logic                 redirect,
   input  logic [31:1]          redirect_pc,
   output logic                 pkt_valid,
   output dec_pkg::fetch_pkt_t  pkt
);

   logic [31:1] pc_q;       // pc of the next accepted word
   logic        is_pc4;     // incoming word is 32-bit
   logic [31:1] pc_step;    // halfword step for the pc

   // low two bits both set means a full 32-bit encoding
   assign is_pc4  = &fetch_instr[1:0];
   assign pc_step = is_pc4 ? 31'd2 : 31'd1;         // 4 or 2 bytes, in halfwords

   // pc register, redirect wins over a same-cycle fetch
   always_ff @(posedge clk) begin
      if (reset) begin
         pc_q <= dec_pkg::RESET_PC;
      end else if (redirect) begin
         pc_q <= redirect_pc;
      end else if (fetch_valid) begin
         pc_q <= pc_q + pc_step;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pkt_valid <= 1'b0;
      end else begin
         pkt_valid <= fetch_valid & ~redirect;      // word in flight is dropped on redirect
      end
   end

   // payload only, qualified by pkt_valid
   always_ff @(posedge clk) begin
      if (fetch_valid) begin
         pkt.instr     <= fetch_instr;
         pkt.pc        <= pc_q;
         pkt.pc4       <= is_pc4;
         pkt.icaf      <= fetch_icaf;
         pkt.icaf_type <= fetch_icaf_type;
         pkt.dbecc     <= fetch_dbecc;
      end
   end

endmodule

//--- logic/inst_buffer.sv
////////////////////////////////////////////////////////////
// inst_buffer
//   circular packet queue of IB_DEPTH entries
//   occupancy count, fetch_ready and redirect flush
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module inst_buffer (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 pkt_valid,
   input  dec_pkg::fetch_pkt_t  pkt,
   input  logic                 pop,
   input  logic                 redirect,
   output logic                 head_valid,
   output dec_pkg::fetch_pkt_t  head,
   output logic                 fetch_ready
);

   localparam logic [dec_pkg::IB_PTR_W-1:0] PTR_LAST =
      dec_pkg::IB_PTR_W'(dec_pkg::IB_DEPTH - 1);
   localparam logic [dec_pkg::IB_CNT_W-1:0] READY_MAX =
      dec_pkg::IB_CNT_W'(dec_pkg::IB_DEPTH - 2);    // one slot kept for the word in flight

   dec_pkg::fetch_pkt_t mem [dec_pkg::IB_DEPTH];

   logic [dec_pkg::IB_PTR_W-1:0] wr_ptr;
   logic [dec_pkg::IB_PTR_W-1:0] rd_ptr;
   logic [dec_pkg::IB_CNT_W-1:0] count;
   logic                          do_pop;

   assign head_valid  = (count != '0);
   assign head        = mem[rd_ptr];
   assign fetch_ready = (count <= READY_MAX);
   assign do_pop      = pop & head_valid;         // never pop an empty queue

   // storage, written at the tail
   always_ff @(posedge clk) begin
      if (pkt_valid) begin
         mem[wr_ptr] <= pkt;
      end
   end

   // pointers and occupancy
   always_ff @(posedge clk) begin
      if (reset || redirect) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (pkt_valid) begin
            wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
         end
         case ({pkt_valid, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;                // push and pop together, or idle
         endcase
      end
   end

endmodule

//--- logic/dec_ib_ctl.sv
////////////////////////////////////////////////////////////
// dec_ib_ctl
//   debug abstract command to instruction translation
//   debug/buffer select, issue packet, pop and taken
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dec_ib_ctl (
   input  logic                 head_valid,
   input  dec_pkg::fetch_pkt_t  head,
   input  logic                 dbg_cmd_valid,
   input  dec_pkg::dbg_cmd_t    dbg_cmd,
   input  logic                 dec_stall,
   output logic                 pop,
   output logic                 dbg_cmd_taken,
   output dec_pkg::dec_pkt_t    issue
);

   logic        dbg_take;    // gpr or csr command, turns into an instruction
   logic        dbg_skip;    // mem or reserved, dropped right away
   logic        rd_gpr;
   logic        wr_gpr;
   logic        rd_csr;
   logic        wr_csr;
   logic [4:0]  dreg;
   logic [11:0] dcsr;
   logic [31:0] dbg_instr;

   assign dbg_take = dbg_cmd_valid & ((dbg_cmd.cmd_type == dec_pkg::DBG_GPR) |
                                      (dbg_cmd.cmd_type == dec_pkg::DBG_CSR));
   assign dbg_skip = dbg_cmd_valid & ~dbg_take;

   assign rd_gpr = (dbg_cmd.cmd_type == dec_pkg::DBG_GPR) & ~dbg_cmd.write;
   assign wr_gpr = (dbg_cmd.cmd_type == dec_pkg::DBG_GPR) &  dbg_cmd.write;
   assign rd_csr = (dbg_cmd.cmd_type == dec_pkg::DBG_CSR) & ~dbg_cmd.write;
   assign wr_csr = (dbg_cmd.cmd_type == dec_pkg::DBG_CSR) &  dbg_cmd.write;

   assign dreg = dbg_cmd.addr[4:0];
   assign dcsr = dbg_cmd.addr[11:0];

   // instruction the debug command becomes
   always_comb begin
      dbg_instr = '0;
      if (rd_gpr) begin
         dbg_instr = {7'd0, 5'd0, dreg, dec_pkg::F3_OR, 5'd0, dec_pkg::OPC_REG};  // or x0,reg,x0
      end else if (wr_gpr) begin
         dbg_instr = {7'd0, 5'd0, 5'd0, dec_pkg::F3_OR, dreg, dec_pkg::OPC_REG};  // or reg,x0,x0
      end else if (rd_csr) begin
         dbg_instr = {dcsr, 5'd0, dec_pkg::F3_CSRRS, 5'd0, dec_pkg::OPC_SYS};
      end else if (wr_csr) begin
         dbg_instr = {dcsr, 5'd0, dec_pkg::F3_CSRRW, 5'd0, dec_pkg::OPC_SYS};
      end
   end

   // debug path assumes a halted core with an empty pipe
   always_comb begin
      issue = '0;
      if (dbg_take) begin
         issue.valid       = ~dec_stall;
         issue.inst.instr  = dbg_instr;
         issue.inst.pc4    = 1'b1;                  // pc and fault fields stay zero
         issue.is_debug    = 1'b1;
         issue.wdata_rs1   = dbg_cmd.write;         // write data comes in on rs1
         issue.debug_fence = wr_csr & (dcsr == dec_pkg::DEBUG_FENCE_CSR);
      end else begin
         issue.valid = head_valid & ~dec_stall;
         issue.inst  = head;
      end
   end

   assign pop           = head_valid & ~dec_stall & ~dbg_take;  // head leaves only on issue
   assign dbg_cmd_taken = dbg_skip | (dbg_take & ~dec_stall);

endmodule

//--- logic/dec_stage.sv
////////////////////////////////////////////////////////////
// dec_stage
//   decode register for the issued packet
//   op class sort and rd/rs1 field extraction
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dec_stage (
   input  logic                clk,
   input  logic                reset,
   input  dec_pkg::dec_pkt_t   issue,
   output logic                dec_valid,
   output dec_pkg::dec_out_t   dec_out
);

   logic [4:0]         major;     // instr[6:2]
   logic [2:0]         funct3;
   dec_pkg::op_class_e op_class;
   dec_pkg::dec_out_t  dec_d;     // next value of the decode register

   assign major  = issue.inst.instr[6:2];
   assign funct3 = issue.inst.instr[14:12];

   // class by major opcode, compressed words skip the table
   always_comb begin
      op_class = dec_pkg::OP_ILLEGAL;
      if (!issue.inst.pc4) begin
         op_class = dec_pkg::OP_COMPRESSED;
      end else begin
         case (major)
            dec_pkg::MAJ_OP:     op_class = dec_pkg::OP_ALU;
            dec_pkg::MAJ_OP_IMM: op_class = dec_pkg::OP_ALU_IMM;
            dec_pkg::MAJ_LOAD:   op_class = dec_pkg::OP_LOAD;
            dec_pkg::MAJ_STORE:  op_class = dec_pkg::OP_STORE;
            dec_pkg::MAJ_BRANCH: op_class = dec_pkg::OP_BRANCH;
            dec_pkg::MAJ_JAL:    op_class = dec_pkg::OP_JAL;
            dec_pkg::MAJ_JALR:   op_class = dec_pkg::OP_JALR;
            dec_pkg::MAJ_SYSTEM: begin
               // csr ops carry a nonzero funct3
               if (funct3 != dec_pkg::F3_PRIV) begin
                  op_class = dec_pkg::OP_CSR;
               end else begin
                  op_class = dec_pkg::OP_SYSTEM;
               end
            end
            default:             op_class = dec_pkg::OP_ILLEGAL;
         endcase
      end
   end

   always_comb begin
      dec_d.inst        = issue.inst;
      dec_d.is_debug    = issue.is_debug;
      dec_d.wdata_rs1   = issue.wdata_rs1;
      dec_d.debug_fence = issue.debug_fence;
      dec_d.op_class    = op_class;
      dec_d.rd          = issue.inst.instr[11:7];
      dec_d.rs1         = issue.inst.instr[19:15];
   end

   // one-cycle valid per issued packet
   always_ff @(posedge clk) begin
      if (reset) begin
         dec_valid <= 1'b0;
      end else begin
         dec_valid <= issue.valid;
      end
   end

   // contents hold when nothing issues, so a stall keeps dec_out
   always_ff @(posedge clk) begin
      if (issue.valid) begin
         dec_out <= dec_d;
      end
   end

endmodule

//--- logic/dec_front_top.sv
////////////////////////////////////////////////////////////
// dec_front_top
//   fetch_pack -> inst_buffer -> dec_ib_ctl -> dec_stage
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dec_front_top (
   input  logic                clk,
   input  logic                reset,
   input  logic                fetch_valid,
   input  logic [31:0]         fetch_instr,
   input  logic                fetch_icaf,
   input  logic [1:0]          fetch_icaf_type,
   input  logic                fetch_dbecc,
   input  logic                redirect,
   input  logic [31:1]         redirect_pc,
   input  logic                dbg_cmd_valid,
   input  dec_pkg::dbg_cmd_t   dbg_cmd,
   input  logic                dec_stall,
   output logic                fetch_ready,
   output logic                dbg_cmd_taken,
   output logic                dec_valid,
   output dec_pkg::dec_out_t   dec_out
);

   logic                pkt_valid;   // fetch register to queue
   dec_pkg::fetch_pkt_t pkt;
   logic                head_valid;  // queue head to select
   dec_pkg::fetch_pkt_t head;
   logic                pop;
   dec_pkg::dec_pkt_t   issue;       // select to decode register

   fetch_pack u_fetch_pack (
      .clk             (clk),
      .reset           (reset),
      .fetch_valid     (fetch_valid),
      .fetch_instr     (fetch_instr),
      .fetch_icaf      (fetch_icaf),
      .fetch_icaf_type (fetch_icaf_type),
      .fetch_dbecc     (fetch_dbecc),
      .redirect        (redirect),
      .redirect_pc     (redirect_pc),
      .pkt_valid       (pkt_valid),
      .pkt             (pkt)
   );

   inst_buffer u_inst_buffer (
      .clk         (clk),
      .reset       (reset),
      .pkt_valid   (pkt_valid),
      .pkt         (pkt),
      .pop         (pop),
      .redirect    (redirect),
      .head_valid  (head_valid),
      .head        (head),
      .fetch_ready (fetch_ready)
   );

   dec_ib_ctl u_dec_ib_ctl (
      .head_valid    (head_valid),
      .head          (head),
      .dbg_cmd_valid (dbg_cmd_valid),
      .dbg_cmd       (dbg_cmd),
      .dec_stall     (dec_stall),
      .pop           (pop),
      .dbg_cmd_taken (dbg_cmd_taken),
      .issue         (issue)
   );

   dec_stage u_dec_stage (
      .clk       (clk),
      .reset     (reset),
      .issue     (issue),
      .dec_valid (dec_valid),
      .dec_out   (dec_out)
   );

endmodule

//--- bench/dec_front_tb.sv
////////////////////////////////////////////////////////////
// dec_front_tb
//   clock, reset and stimulus for dec_front_top
//   expected decode queue built from the decode rules
//   checking assertions, watchdog and summary
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dec_front_tb;

   localparam int CLK_PERIOD   = 100;
   localparam int DRIVE_DLY    = 1;                  // inputs move 1 ns after the edge
   localparam int RESET_CYCLES = 10;
   localparam int RAND_SEED    = 8;
   localparam int N_FETCH      = 40;
   localparam int N_STALLED    = 12;
   localparam int LONG_STALL   = 20;
   // cycle budget per test summed for the watchdog
   localparam int T_FETCH  = 8 * N_FETCH + 40;
   localparam int T_DEBUG  = 14 * 25;
   localparam int T_STALL  = LONG_STALL + 8 * N_STALLED + 40;
   localparam int T_MISC   = 300;                    // redirect and op classes
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + T_FETCH + T_DEBUG + T_STALL + T_MISC + 200;

   logic               clk;
   logic               reset;
   logic               fetch_valid;
   logic [31:0]        fetch_instr;
   logic               fetch_icaf;
   logic [1:0]         fetch_icaf_type;
   logic               fetch_dbecc;
   logic               redirect;
   logic [31:1]        redirect_pc;
   logic               dbg_cmd_valid;
   dec_pkg::dbg_cmd_t  dbg_cmd;
   logic               dec_stall;
   logic               fetch_ready;
   logic               dbg_cmd_taken;
   logic               dec_valid;
   dec_pkg::dec_out_t  dec_out;

   dec_pkg::dec_out_t  exp_q[$];      // expected dec_out values with the oldest at the front
   dec_pkg::dec_out_t  out_q;         // dec_out one cycle back
   logic [31:1]        model_pc;      // pc the next accepted word gets
   logic               stall_q;       // stall applied at the last edge
   logic               taken_q;
   logic               saw_not_ready;
   string              cur_test;
   int                 errors;
   int                 checks;
   int                 tests_run;
   int                 tests_failed;
   int                 test_err_start;
   int                 outstanding;   // accepted fetch words not yet decoded

   dec_front_top u_dut (
      .clk             (clk),
      .reset           (reset),
      .fetch_valid     (fetch_valid),
      .fetch_instr     (fetch_instr),
      .fetch_icaf      (fetch_icaf),
      .fetch_icaf_type (fetch_icaf_type),
      .fetch_dbecc     (fetch_dbecc),
      .redirect        (redirect),
      .redirect_pc     (redirect_pc),
      .dbg_cmd_valid   (dbg_cmd_valid),
      .dbg_cmd         (dbg_cmd),
      .dec_stall       (dec_stall),
      .fetch_ready     (fetch_ready),
      .dbg_cmd_taken   (dbg_cmd_taken),
      .dec_valid       (dec_valid),
      .dec_out         (dec_out)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // op class straight from the major opcode table
   function automatic dec_pkg::op_class_e classify(input logic [31:0] instr);
      if (instr[1:0] != 2'b11) return dec_pkg::OP_COMPRESSED;
      case (instr[6:2])
         5'b01100: return dec_pkg::OP_ALU;
         5'b00100: return dec_pkg::OP_ALU_IMM;
         5'b00000: return dec_pkg::OP_LOAD;
         5'b01000: return dec_pkg::OP_STORE;
         5'b11000: return dec_pkg::OP_BRANCH;
         5'b11011: return dec_pkg::OP_JAL;
         5'b11001: return dec_pkg::OP_JALR;
         5'b11100: return (instr[14:12] != 3'b000) ? dec_pkg::OP_CSR : dec_pkg::OP_SYSTEM;
         default:  return dec_pkg::OP_ILLEGAL;
      endcase
   endfunction

   function automatic dec_pkg::dec_out_t expect_word(input logic [31:0] instr,
         input logic [31:1] pc, input logic icaf, input logic [1:0] itype, input logic dbecc);
      dec_pkg::dec_out_t e;
      e                = '0;
      e.inst.instr     = instr;
      e.inst.pc        = pc;
      e.inst.pc4       = (instr[1:0] == 2'b11);
      e.inst.icaf      = icaf;
      e.inst.icaf_type = itype;
      e.inst.dbecc     = dbecc;
      e.op_class       = classify(instr);
      e.rd             = instr[11:7];
      e.rs1            = instr[19:15];
      return e;
   endfunction

   function automatic dec_pkg::dec_out_t expect_debug(input dec_pkg::dbg_cmd_t cmd);
      dec_pkg::dec_out_t e;
      logic [31:0]       instr;
      logic [4:0]        r;
      logic [11:0]       csr;
      r   = cmd.addr[4:0];
      csr = cmd.addr[11:0];
      if (cmd.cmd_type == dec_pkg::DBG_GPR && !cmd.write) begin
         instr = {12'h000, r, 3'b110, 5'd0, 7'b0110011};      // or x0, reg, x0
      end else if (cmd.cmd_type == dec_pkg::DBG_GPR) begin
         instr = {12'h000, 5'd0, 3'b110, r, 7'b0110011};      // or reg, x0, x0
      end else if (!cmd.write) begin
         instr = {csr, 5'd0, 3'b010, 5'd0, 7'b1110011};       // csrrs x0, csr, x0
      end else begin
         instr = {csr, 5'd0, 3'b001, 5'd0, 7'b1110011};       // csrrw x0, csr, x0
      end
      e               = '0;
      e.inst.instr    = instr;
      e.inst.pc4      = 1'b1;
      e.is_debug      = 1'b1;
      e.wdata_rs1     = cmd.write;
      e.debug_fence   = cmd.write && (cmd.cmd_type == dec_pkg::DBG_CSR) && (csr == 12'h7c4);
      e.op_class      = classify(instr);
      e.rd            = instr[11:7];
      e.rs1           = instr[19:15];
      return e;
   endfunction

   // half 32-bit, half 16-bit words
   function automatic logic [31:0] random_instr();
      logic [31:0] r;
      r = $urandom;
      if ($urandom % 2 == 0) r[1:0] = 2'b11;
      else r[1:0] = 2'($urandom % 3);
      return r;
   endfunction

   // checks sampled mid-cycle where every DUT output is settled
   always @(negedge clk) begin
      if (reset) begin
         stall_q     <= 1'b0;
         taken_q     <= 1'b0;
         outstanding = 0;
      end else begin
         if (dec_valid) begin
            checks++;
            assert (exp_q.size() != 0) else begin
               $display("%s: decode output appeared with no packet expected", cur_test);
               errors++;
            end
            if (exp_q.size() != 0) begin
               assert (dec_out === exp_q[0]) else begin
                  $display("[ERROR] %s: expected %h, actual %h", cur_test, exp_q[0], dec_out);
                  errors++;
               end
               void'(exp_q.pop_front());
            end
            if (!dec_out.is_debug && outstanding > 0) outstanding--;
         end
         if (stall_q) begin
            assert (dec_out === out_q) else begin
               $display("[ERROR] %s: expected %h, actual %h", cur_test, out_q, dec_out);
               errors++;
            end
            assert (!dec_valid) else begin
               $display("%s: dec_valid pulsed while decode was stalled", cur_test);
               errors++;
            end
         end
         assert (!(dbg_cmd_taken && taken_q)) else begin
            $display("%s: dbg_cmd_taken stayed high for more than one cycle", cur_test);
            errors++;
         end
         assert (outstanding > 2 || fetch_ready) else begin
            $display("%s: fetch_ready low with the buffer nearly empty", cur_test);
            errors++;
         end
         if (redirect) outstanding = 0;                 // queue and fetch reg flushed
         else if (fetch_valid) outstanding++;
         stall_q <= dec_stall;
         taken_q <= dbg_cmd_taken;
      end
      out_q <= dec_out;
   end

   task automatic drive_word(input logic [31:0] instr, input logic icaf,
         input logic [1:0] itype, input logic dbecc);
      fetch_valid     = 1'b1;
      fetch_instr     = instr;
      fetch_icaf      = icaf;
      fetch_icaf_type = itype;
      fetch_dbecc     = dbecc;
      exp_q.push_back(expect_word(instr, model_pc, icaf, itype, dbecc));
      model_pc = model_pc + ((instr[1:0] == 2'b11) ? 31'd2 : 31'd1);  // 4 or 2 bytes
   endtask

   task automatic send_word(input logic [31:0] instr);
      int n;
      n = 0;
      while (!fetch_ready && n < 50) begin
         @(posedge clk);
         #DRIVE_DLY;
         n++;
      end
      if (!fetch_ready) begin
         $display("%s: fetch_ready stayed low, word not sent", cur_test);
         errors++;
      end else begin
         drive_word(instr, 1'b0, 2'b00, 1'b0);
         @(posedge clk);
         #DRIVE_DLY;
         fetch_valid = 1'b0;
      end
   endtask

   // random faulty words with the stall held for long_stall cycles and random after
   task automatic stream_words(input int n, input int long_stall, input int stall_pct);
      int sent;
      int cyc;
      sent = 0;
      cyc  = 0;
      while (sent < n && cyc < long_stall + 8 * n + 20) begin
         dec_stall = (cyc < long_stall) ? 1'b1 : (($urandom % 100) < stall_pct);
         if (!fetch_ready) saw_not_ready = 1'b1;
         if (fetch_ready) begin
            drive_word(random_instr(), 1'($urandom), 2'($urandom), 1'($urandom));
            sent++;
         end else begin
            fetch_valid = 1'b0;
         end
         @(posedge clk);
         #DRIVE_DLY;
         cyc++;
      end
      fetch_valid = 1'b0;
      dec_stall   = 1'b0;
      if (sent < n) begin
         $display("%s: only %0d of %0d words were accepted", cur_test, sent, n);
         errors++;
      end
   endtask

   // hold the command until taken and stall for the first stall_cycles
   task automatic run_dbg(input logic write, input dec_pkg::dbg_type_e t,
         input logic [31:0] addr, input int stall_cycles);
      int n;
      dbg_cmd.write    = write;
      dbg_cmd.cmd_type = t;
      dbg_cmd.addr     = addr;
      dbg_cmd_valid    = 1'b1;
      dec_stall        = (stall_cycles > 0);
      if (t == dec_pkg::DBG_GPR || t == dec_pkg::DBG_CSR) exp_q.push_back(expect_debug(dbg_cmd));
      n = 0;
      @(negedge clk);
      while (!dbg_cmd_taken && n < 20) begin
         @(posedge clk);
         #DRIVE_DLY;
         n++;
         dec_stall = (n < stall_cycles);
         @(negedge clk);
      end
      if (!dbg_cmd_taken) begin
         $display("%s: debug command was never taken", cur_test);
         errors++;
      end
      @(posedge clk);
      #DRIVE_DLY;
      dbg_cmd_valid = 1'b0;
      dec_stall     = 1'b0;
      @(posedge clk);                                // idle gap between commands
      #DRIVE_DLY;
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < 100) begin
         @(posedge clk);
         #DRIVE_DLY;
         n++;
      end
      if (exp_q.size() != 0) begin
         $display("%s: %0d expected packets never came out", cur_test, exp_q.size());
         errors++;
         exp_q.delete();
      end
      repeat (3) @(posedge clk);                     // room for stray extra outputs
      #DRIVE_DLY;
   endtask

   task automatic begin_test(input string name);
      cur_test       = name;
      test_err_start = errors;
      tests_run++;
   endtask

   task automatic end_test();
      if (errors != test_err_start) tests_failed++;
      $display("test %-20s done, %0d errors", cur_test, errors - test_err_start);
   endtask

   logic [31:0] class_words [11] = '{
      32'h00b50533, 32'h00150513, 32'h0005a503, 32'h00a5a023,   // add addi lw sw
      32'h00b50463, 32'h008000ef, 32'h000080e7, 32'h30529073,   // beq jal jalr csrrw
      32'h00000073, 32'h00004501, 32'h0000007f                  // ecall c.li illegal
   };

   initial begin
      void'($urandom(RAND_SEED));
      reset           = 1'b1;
      fetch_valid     = 1'b0;
      fetch_instr     = '0;
      fetch_icaf      = 1'b0;
      fetch_icaf_type = 2'b00;
      fetch_dbecc     = 1'b0;
      redirect        = 1'b0;
      redirect_pc     = '0;
      dbg_cmd_valid   = 1'b0;
      dbg_cmd         = '0;
      dec_stall       = 1'b0;
      errors          = 0;
      checks          = 0;
      tests_run       = 0;
      tests_failed    = 0;
      saw_not_ready   = 1'b0;
      model_pc        = 31'h0;                       // pc after reset
      cur_test        = "reset";
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DLY;
      reset = 1'b0;
      assert (fetch_ready && !dec_valid && !dbg_cmd_taken) else begin
         $display("outputs not idle after reset");
         errors++;
      end

      begin_test("fetch_order");
      stream_words(N_FETCH, 0, 0);
      wait_drain();
      end_test();

      begin_test("debug_cmds");
      repeat (2) begin
         run_dbg(1'b0, dec_pkg::DBG_GPR, $urandom, int'($urandom % 3));
         run_dbg(1'b1, dec_pkg::DBG_GPR, $urandom, int'($urandom % 3));
         run_dbg(1'b0, dec_pkg::DBG_CSR, $urandom, int'($urandom % 3));
         run_dbg(1'b1, dec_pkg::DBG_CSR, $urandom, int'($urandom % 3));
      end
      run_dbg(1'b0, dec_pkg::DBG_MEM, $urandom, 0);  // taken with nothing decoded
      run_dbg(1'b1, dec_pkg::DBG_MEM, $urandom, 1);
      run_dbg(1'b0, dec_pkg::DBG_RSVD, $urandom, 0);
      wait_drain();
      end_test();

      begin_test("debug_fence");
      run_dbg(1'b1, dec_pkg::DBG_CSR, 32'h0000_07c4, 0);
      run_dbg(1'b1, dec_pkg::DBG_CSR, 32'h0000_07c5, 0);
      run_dbg(1'b0, dec_pkg::DBG_CSR, 32'h0000_07c4, 0);
      wait_drain();
      end_test();

      begin_test("stall_backpressure");
      saw_not_ready = 1'b0;
      stream_words(N_STALLED, LONG_STALL, 30);
      wait_drain();
      assert (saw_not_ready) else begin
         $display("%s: fetch_ready never dropped during the long stall", cur_test);
         errors++;
      end
      end_test();

      begin_test("redirect");
      dec_stall = 1'b1;                              // keep old words in the pipe
      send_word(random_instr());
      send_word(random_instr());
      redirect    = 1'b1;
      redirect_pc = 31'($urandom);
      exp_q.delete();                                // flushed words must not show up
      model_pc    = redirect_pc;
      @(posedge clk);
      #DRIVE_DLY;
      redirect  = 1'b0;
      dec_stall = 1'b0;
      repeat (4) send_word(random_instr());
      wait_drain();
      end_test();

      begin_test("op_classes");
      foreach (class_words[i]) send_word(class_words[i]);
      wait_drain();
      end_test();

      $display("tests %0d, failing %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
      $display("Some tests failed");
      $finish;
   end

endmodule

//--- dec_front.f
logic/dec_pkg.sv
logic/fetch_pack.sv
logic/inst_buffer.sv
logic/dec_ib_ctl.sv
logic/dec_stage.sv
logic/dec_front_top.sv
bench/dec_front_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the dec_front testbench with Verilator and run it
# the run counts as passed only if the pass line shows up in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module dec_front_tb -f dec_front.f -o dec_front_sim \
   && ./obj_dir/dec_front_sim | tee /dev/stderr | grep -q "All tests passed" \
   && echo "run_sim: simulation passed" \
   || { echo "run_sim: simulation failed"; exit 1; }
